// File: rtl/md5_pkg.sv
`default_nettype none

package md5_pkg;
    localparam int md5_word_w = 32;
    localparam int md5_words  = 16;
    localparam int md5_addr_w = 4;
    localparam int md5_steps  = 64;
    localparam int kb_w       = 440;                     // 55 bytes of candidate

    localparam logic [63:0] kb_len_bits = 64'(kb_w);      // goes into words 14 and 15

    // A, B, C, D from msb down
    localparam logic [127:0] md5_iv = {32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476};

    // per-round shifts, indexed by {round, step[1:0]}
    localparam logic [4:0] md5_s [0:15] = '{
        5'd7, 5'd12, 5'd17, 5'd22, 5'd5, 5'd9, 5'd14, 5'd20,
        5'd4, 5'd11, 5'd16, 5'd23, 5'd6, 5'd10, 5'd15, 5'd21
    };

    localparam logic [31:0] md5_k [0:63] = '{           // floor(abs(sin(i + 1)) * 2^32)
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // MD5 words are little-endian byte groups
    function automatic logic [31:0] md5_bswap(input logic [31:0] x);
        return {x[7:0], x[15:8], x[23:16], x[31:24]};
    endfunction
endpackage

`default_nettype wire

// File: rtl/aes_pkg.sv
`default_nettype none

package aes_pkg;
    typedef union packed {
        logic [15:0][7:0] b;    // byte k of the block sits in b[15-k]
        logic [3:0][31:0] w;    // column c sits in w[3-c]
    } aes_state_u;

    localparam int aes_rounds = 10;

    function automatic logic [7:0] xtime(input logic [7:0] x);
        return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    endfunction

    // GF(2^8) product, shift-and-add
    function automatic logic [7:0] gf_mul(input logic [7:0] x, input logic [7:0] y);
        logic [7:0] p;
        logic [7:0] a;
        p = 8'h00;
        a = x;
        for (int i = 0; i < 8; i++) begin
            if (y[i])
                p = p ^ a;
            a = xtime(a);
        end
        return p;
    endfunction

    function automatic logic [7:0] aes_sbox(input logic [7:0] x);
        logic [7:0] sq;
        logic [7:0] inv;
        sq  = x;
        inv = 8'h01;
        for (int k = 1; k < 8; k++) begin   // x^254 = x^2 * x^4 * ... * x^128
            sq  = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
        // affine map
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction
endpackage

`default_nettype wire

// File: rtl/md5_core.sv
`timescale 1ns/100ps
`default_nettype none

module md5_core (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall,
    input  logic                           we,
    input  logic                           start,
    input  logic [md5_pkg::md5_addr_w-1:0] waddr,
    input  logic [md5_pkg::md5_word_w-1:0] wdata,
    output logic                           done,
    output logic [127:0]                   digest
);
    import md5_pkg::*;

    logic [md5_word_w-1:0]        mem [md5_words];     // message block
    logic [md5_word_w-1:0]        a, b, c, d;
    logic [$clog2(md5_steps)-1:0] step;
    logic                         busy;
    logic                         last;
    logic [md5_word_w-1:0]        f;
    logic [md5_addr_w-1:0]        g;                   // word index for this step
    logic [md5_word_w-1:0]        sum;
    logic [2*md5_word_w-1:0]      rot;
    logic [md5_word_w-1:0]        b_n;

    always_ff @(posedge clk) begin
        if (we && !stall)
            mem[waddr] <= wdata;
    end

    assign last = step == md5_steps - 1;

    always_comb begin
        case (step[5:4])
            2'd0: begin
                f = (b & c) | (~b & d);
                g = step[3:0];
            end
            2'd1: begin
                f = (d & b) | (~d & c);
                g = step[3:0] * 4'd5 + 4'd1;
            end
            2'd2: begin
                f = b ^ c ^ d;
                g = step[3:0] * 4'd3 + 4'd5;
            end
            default: begin
                f = c ^ (b | ~d);
                g = step[3:0] * 4'd7;
            end
        endcase
        sum = a + f + md5_k[step] + mem[g];
        rot = {sum, sum} << md5_s[{step[5:4], step[1:0]}];   // rotate left via upper half
        b_n = b + rot[63:32];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else if (!stall) begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (start) begin
                {a, b, c, d} <= md5_iv;
            end else if (busy) begin
                a <= d;
                b <= b_n;
                c <= b;
                d <= c;
                if (last)   // final step folded with the chaining add
                    digest <= {md5_bswap(md5_iv[127:96] + d), md5_bswap(md5_iv[95:64] + b_n),
                               md5_bswap(md5_iv[63:32] + b), md5_bswap(md5_iv[31:0] + c)};
            end
        end
    end

    // control must finish loading before it kicks off the hash
    a_no_we_with_start: assert property (@(posedge clk) disable iff (rst) !(we && start));

endmodule

`default_nettype wire

// File: rtl/aes_core.sv
`timescale 1ns/100ps
`default_nettype none

module aes_core (
    input  logic         clk,
    input  logic         rst,
    input  logic         stall,
    input  logic         start,
    input  logic [127:0] din,
    input  logic [127:0] key,
    output logic         done,
    output logic [127:0] dout
);
    import aes_pkg::*;

    aes_state_u st;         // cipher state
    aes_state_u rk;         // current round key
    aes_state_u sr;         // after SubBytes and ShiftRows
    aes_state_u mc;         // after MixColumns
    aes_state_u rk_n;       // next round key
    logic [7:0] rcon;
    logic [3:0] round;
    logic       busy;
    logic [3:0] chk_cnt;    // unstalled cycles since start
    logic [31:0] sw;        // SubWord(RotWord(last column))
    logic [7:0] s0, s1, s2, s3;

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                // row r shifts left by r columns
                sr.b[15 - r - 4 * c] = aes_sbox(st.b[15 - r - 4 * ((c + r) % 4)]);
            end
        end
        for (int c = 0; c < 4; c++) begin
            s0 = sr.w[3 - c][31:24];
            s1 = sr.w[3 - c][23:16];
            s2 = sr.w[3 - c][15:8];
            s3 = sr.w[3 - c][7:0];
            mc.w[3 - c] = {xtime(s0) ^ xtime(s1) ^ s1 ^ s2 ^ s3,
                           s0 ^ xtime(s1) ^ xtime(s2) ^ s2 ^ s3,
                           s0 ^ s1 ^ xtime(s2) ^ xtime(s3) ^ s3,
                           xtime(s0) ^ s0 ^ s1 ^ s2 ^ xtime(s3)};
        end
        sw = {aes_sbox(rk.w[0][23:16]), aes_sbox(rk.w[0][15:8]),
              aes_sbox(rk.w[0][7:0]), aes_sbox(rk.w[0][31:24])};
        rk_n.w[3] = rk.w[3] ^ sw ^ {rcon, 24'h000000};
        rk_n.w[2] = rk.w[2] ^ rk_n.w[3];
        rk_n.w[1] = rk.w[1] ^ rk_n.w[2];
        rk_n.w[0] = rk.w[0] ^ rk_n.w[1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            round <= '0;
            done  <= 1'b0;
        end else if (!stall) begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                round <= 4'd1;
            end else if (busy) begin
                round <= round + 4'd1;
                if (round == 4'(aes_rounds)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (start) begin
                st   <= din ^ key;      // initial AddRoundKey
                rk   <= key;
                rcon <= 8'h01;
            end else if (busy) begin
                st   <= ((round == 4'(aes_rounds)) ? sr : mc) ^ rk_n;  // no MixColumns at the end
                rk   <= rk_n;
                rcon <= xtime(rcon);
            end
        end
    end

    assign dout = st;

    always_ff @(posedge clk) begin
        if (rst)
            chk_cnt <= '0;
        else if (!stall) begin
            if (start)
                chk_cnt <= 4'd1;
            else if (chk_cnt == 4'(aes_rounds + 1))
                chk_cnt <= '0;
            else if (chk_cnt != '0)
                chk_cnt <= chk_cnt + 4'd1;
        end
    end

    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        done |-> chk_cnt == 4'(aes_rounds + 1));

endmodule

`default_nettype wire

// File: rtl/kb_check_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module kb_check_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall,
    input  logic                           start,
    input  logic [md5_pkg::kb_w-1:0]       kb,
    input  logic [127:0]                   in_buf,
    output logic                           md5_we,
    output logic                           md5_start,
    output logic                           aes_start,
    output logic [md5_pkg::md5_addr_w-1:0] md5_waddr,
    output logic [md5_pkg::md5_word_w-1:0] md5_wdata,
    input  logic                           md5_done,
    input  logic                           aes_done,
    input  logic [127:0]                   md5_digest,
    input  logic [127:0]                   aes_out,
    output logic [127:0]                   key,
    output logic                           valid,
    output logic                           done
);
    import md5_pkg::*;

    enum logic [1:0] {st_idle, st_load, st_hash, st_cipher} state;

    logic [md5_addr_w-1:0]           cnt;       // word being written, 0 in idle
    logic [kb_w-1:0]                 kb_q;
    logic [127:0]                    buf_q;     // expected ciphertext
    logic [md5_words*md5_word_w-1:0] msg;       // padded block, byte 0 at msb
    logic [md5_word_w-1:0]           slice;
    logic                            match;

    always_comb begin
        // word 0 goes out in the start cycle, before kb is captured
        msg = {(state == st_idle) ? kb : kb_q, 8'h80, 64'h0};
        for (int i = 0; i < 8; i++) begin
            msg[8 * i +: 8] = kb_len_bits[63 - 8 * i -: 8];   // length bytes, lsb first
        end
        slice = msg[$bits(msg) - 1 - md5_word_w * cnt -: md5_word_w];
    end

    assign md5_we    = (state == st_idle && start) || state == st_load;
    assign md5_waddr = cnt;
    assign md5_wdata = md5_bswap(slice);
    assign match     = aes_out == buf_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            cnt       <= '0;
            md5_start <= 1'b0;
            aes_start <= 1'b0;
            done      <= 1'b0;
            valid     <= 1'b0;
            key       <= '0;
        end else if (!stall) begin
            md5_start <= 1'b0;
            aes_start <= 1'b0;
            done      <= 1'b0;
            case (state)
                st_idle: if (start) begin
                    state <= st_load;
                    cnt   <= cnt + 1'b1;
                    valid <= 1'b0;
                    key   <= '0;
                end
                st_load: begin
                    cnt <= cnt + 1'b1;  // wraps back to 0
                    if (&cnt) begin
                        state     <= st_hash;
                        md5_start <= 1'b1;
                    end
                end
                st_hash: if (md5_done) begin
                    state     <= st_cipher;
                    aes_start <= 1'b1;  // digest is plaintext and key
                end
                default: if (aes_done) begin
                    state <= st_idle;
                    done  <= 1'b1;
                    valid <= match;
                    key   <= match ? md5_digest : '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && state == st_idle && start) begin
            kb_q  <= kb;
            buf_q <= in_buf;
        end
    end

    // a hash starts only right after the last word is loaded
    a_md5_start_src: assert property (@(posedge clk) disable iff (rst)
        md5_start |-> $past(md5_start) || $past(md5_we && !stall && &md5_waddr));

endmodule

`default_nettype wire

// File: rtl/kb_check_top.sv
`timescale 1ns/100ps
`default_nettype none

module kb_check_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     start,
    input  logic [md5_pkg::kb_w-1:0] kb,
    input  logic [127:0]             in_buf,
    output logic [127:0]             key,
    output logic                     valid,
    output logic                     done
);
    import md5_pkg::*;

    logic                  md5_we;
    logic                  md5_start;
    logic                  md5_done;
    logic [md5_addr_w-1:0] md5_waddr;
    logic [md5_word_w-1:0] md5_wdata;
    logic [127:0]          md5_digest;
    logic                  aes_start;
    logic                  aes_done;
    logic [127:0]          aes_out;

    kb_check_ctrl kb_check_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .start      (start),
        .kb         (kb),
        .in_buf     (in_buf),
        .md5_we     (md5_we),
        .md5_start  (md5_start),
        .aes_start  (aes_start),
        .md5_waddr  (md5_waddr),
        .md5_wdata  (md5_wdata),
        .md5_done   (md5_done),
        .aes_done   (aes_done),
        .md5_digest (md5_digest),
        .aes_out    (aes_out),
        .key        (key),
        .valid      (valid),
        .done       (done)
    );

    md5_core md5_core_i (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .we     (md5_we),
        .start  (md5_start),
        .waddr  (md5_waddr),
        .wdata  (md5_wdata),
        .done   (md5_done),
        .digest (md5_digest)
    );

    aes_core aes_core_i (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .start (aes_start),
        .din   (md5_digest),
        .key   (md5_digest),
        .done  (aes_done),
        .dout  (aes_out)
    );

endmodule

`default_nettype wire

// File: verif/kb_check_vectors.sv
`default_nettype none

package kb_check_vectors;
    // known MD5 answers, message bytes left-aligned in 440 bits
    localparam logic [439:0] abc_msg = {"abc", 416'h0};
    localparam logic [127:0] abc_md5 = 128'h900150983cd24fb0d6963f7d28e17f72;
    localparam logic [439:0] fox_msg = {"The quick brown fox jumps over the lazy dog", 96'h0};
    localparam logic [127:0] fox_md5 = 128'h9e107d9d372bb6826bd81d3542a419d6;

    // AES-128 example from FIPS-197 appendix C.1
    localparam logic [127:0] fips_key = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] fips_pt  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] fips_ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    // candidate key blocks, 55 ASCII bytes each
    localparam logic [439:0] kb_vec [2] = '{
        "candidate key block number one for the md5 to aes test!",
        "a second candidate, all fifty five bytes of it counted."
    };
endpackage

`default_nettype wire

// File: verif/kb_check_tb.sv
`timescale 1ns/100ps
`default_nettype none

module kb_check_tb;
    import kb_check_vectors::*;

    localparam int md5_shift [16] = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
    localparam int run_limit = 1000;   // cycles allowed for one run

    logic                     clk;
    logic                     rst;
    logic                     stall;
    logic                     start;
    logic [439:0]             kb;
    logic [127:0]             in_buf;
    logic [127:0]             key;
    logic                     valid;
    logic                     done;

    logic [31:0]  rng;
    logic         pending;      // an accepted start has no done yet
    logic         idle;
    logic         accepted;
    logic         exp_valid;
    logic [127:0] exp_key;
    logic [127:0] model_out;
    logic [439:0] last_kb;
    int           errors;
    int           err_mark;
    int           tests_pass;
    int           tests_fail;
    int           test_num;

    kb_check_top kb_check_top_i (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .start  (start),
        .kb     (kb),
        .in_buf (in_buf),
        .key    (key),
        .valid  (valid),
        .done   (done)
    );

    always #10 clk = ~clk;

    assign idle     = !pending || done;   // control is back in idle once done shows
    assign accepted = start && !stall && idle;

    always_ff @(posedge clk) begin
        if (rst)
            pending <= 1'b0;
        else if (!stall) begin
            if (accepted)
                pending <= 1'b1;
            else if (done)
                pending <= 1'b0;
        end
    end

    a_done_owned: assert property (@(posedge clk) disable iff (rst) done |-> pending)
        else begin
            errors++;
            $display("done arrived with no accepted start in progress");
        end

    a_valid: assert property (@(posedge clk) disable iff (rst) done |-> valid == exp_valid)
        else begin
            errors++;
            $display("error valid: got %h expected %h", $sampled(valid), exp_valid);
        end

    a_key: assert property (@(posedge clk) disable iff (rst)
        done |-> key == (exp_valid ? exp_key : 128'h0))
        else begin
            errors++;
            $display("error key: got %h expected %h", $sampled(key),
                     exp_valid ? exp_key : 128'h0);
        end

    a_one_cycle: assert property (@(posedge clk) disable iff (rst) done && !stall |=> !done)
        else begin
            errors++;
            $display("done stayed high for more than one unstalled cycle");
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        !accepted |=> (($stable(valid) && $stable(key)) || done))
        else begin
            errors++;
            $display("valid or key changed without a done or an accepted start");
        end

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [439:0] random_kb();
        logic [439:0] v;
        v = '0;
        for (int i = 0; i < 14; i++)
            v = {v[407:0], next_rand()};
        return v;
    endfunction

    // message bytes, 0x80, zeros, then bit length little-endian
    function automatic logic [511:0] pad_block(input logic [439:0] m, input int n);
        logic [511:0] blk;
        logic [63:0]  len;
        blk = '0;
        len = 64'(8 * n);
        for (int i = 0; i < n; i++)
            blk[511 - 8 * i -: 8] = m[439 - 8 * i -: 8];
        blk[511 - 8 * n -: 8] = 8'h80;
        for (int i = 0; i < 8; i++)
            blk[511 - 8 * (56 + i) -: 8] = len[8 * i +: 8];
        return blk;
    endfunction

    function automatic logic [31:0] byte_swap(input logic [31:0] x);
        return {x[7:0], x[15:8], x[23:16], x[31:24]};
    endfunction

    function automatic logic [127:0] md5_of_block(input logic [511:0] blk);
        logic [31:0] x [16];
        logic [31:0] a, b, c, d, f, t, k;
        int          g;
        int          s;
        real         r;
        for (int j = 0; j < 16; j++)
            x[j] = {blk[511 - 32 * j - 24 -: 8], blk[511 - 32 * j - 16 -: 8],
                    blk[511 - 32 * j - 8 -: 8], blk[511 - 32 * j -: 8]};
        a = 32'h67452301;
        b = 32'hefcdab89;
        c = 32'h98badcfe;
        d = 32'h10325476;
        for (int i = 0; i < 64; i++) begin
            case (i / 16)
                0: begin
                    f = (b & c) | (~b & d);
                    g = i;
                end
                1: begin
                    f = (b & d) | (c & ~d);
                    g = (5 * i + 1) % 16;
                end
                2: begin
                    f = b ^ c ^ d;
                    g = (3 * i + 5) % 16;
                end
                default: begin
                    f = c ^ (b | ~d);
                    g = (7 * i) % 16;
                end
            endcase
            r = $sin(i + 1.0);   // sine table built on the fly
            if (r < 0.0)
                r = -r;
            k = 32'(longint'($floor(r * 4294967296.0)));
            s = md5_shift[4 * (i / 16) + i % 4];
            t = a + f + k + x[g];
            a = d;
            d = c;
            c = b;
            b = b + ((t << s) | (t >> (32 - s)));
        end
        return {byte_swap(a + 32'h67452301), byte_swap(b + 32'hefcdab89),
                byte_swap(c + 32'h98badcfe), byte_swap(d + 32'h10325476)};
    endfunction

    // carry-less product reduced by x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gmul(input logic [7:0] x, input logic [7:0] y);
        logic [15:0] p;
        p = '0;
        for (int i = 0; i < 8; i++)
            if (y[i])
                p = p ^ (16'(x) << i);
        for (int i = 15; i >= 8; i--)
            if (p[i])
                p = p ^ (16'h11b << (i - 8));
        return p[7:0];
    endfunction

    function automatic logic [7:0] sbox_of(input logic [7:0] x);
        logic [7:0] inv;
        logic [7:0] y;
        inv = 8'h00;
        for (int v = 1; v < 256; v++)   // search for the inverse
            if (gmul(x, 8'(v)) == 8'h01)
                inv = 8'(v);
        for (int i = 0; i < 8; i++)
            y[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
                 ^ inv[(i + 7) % 8];
        return y ^ 8'h63;
    endfunction

    function automatic logic [127:0] aes_encrypt(input logic [127:0] pt, input logic [127:0] ck);
        logic [7:0]   s [16];
        logic [7:0]   t [16];
        logic [7:0]   k [16];
        logic [7:0]   tmp [4];
        logic [7:0]   rc;
        logic [127:0] out;
        for (int i = 0; i < 16; i++) begin
            k[i] = ck[127 - 8 * i -: 8];
            s[i] = pt[127 - 8 * i -: 8] ^ k[i];
        end
        rc = 8'h01;
        for (int rnd = 1; rnd <= 10; rnd++) begin
            for (int c = 0; c < 4; c++)
                for (int r = 0; r < 4; r++)
                    t[4 * c + r] = sbox_of(s[4 * ((c + r) % 4) + r]);
            for (int c = 0; c < 4; c++) begin
                if (rnd < 10) begin
                    s[4 * c]     = gmul(t[4 * c], 8'h02) ^ gmul(t[4 * c + 1], 8'h03)
                                 ^ t[4 * c + 2] ^ t[4 * c + 3];
                    s[4 * c + 1] = t[4 * c] ^ gmul(t[4 * c + 1], 8'h02)
                                 ^ gmul(t[4 * c + 2], 8'h03) ^ t[4 * c + 3];
                    s[4 * c + 2] = t[4 * c] ^ t[4 * c + 1] ^ gmul(t[4 * c + 2], 8'h02)
                                 ^ gmul(t[4 * c + 3], 8'h03);
                    s[4 * c + 3] = gmul(t[4 * c], 8'h03) ^ t[4 * c + 1] ^ t[4 * c + 2]
                                 ^ gmul(t[4 * c + 3], 8'h02);
                end else begin
                    for (int r = 0; r < 4; r++)
                        s[4 * c + r] = t[4 * c + r];
                end
            end
            tmp[0] = sbox_of(k[13]) ^ rc;
            tmp[1] = sbox_of(k[14]);
            tmp[2] = sbox_of(k[15]);
            tmp[3] = sbox_of(k[12]);
            for (int i = 0; i < 16; i++)
                k[i] = k[i] ^ ((i < 4) ? tmp[i] : k[i - 4]);
            for (int i = 0; i < 16; i++)
                s[i] = s[i] ^ k[i];
            rc = gmul(rc, 8'h02);
        end
        for (int i = 0; i < 16; i++)
            out[127 - 8 * i -: 8] = s[i];
        return out;
    endfunction

    // one run from a start pulse up to done; poke adds starts while busy
    task automatic check_run(input logic [439:0] k, input bit flip, input bit stalls,
                             input bit poke);
        logic [127:0] d;
        logic [127:0] c;
        bit           seen;
        int           n;
        d = md5_of_block(pad_block(k, 55));
        c = aes_encrypt(d, d);
        last_kb = k;
        @(negedge clk);
        exp_valid = !flip;
        exp_key   = d;
        kb        = k;
        in_buf    = flip ? c ^ (128'h1 << (next_rand() % 128)) : c;
        stall     = 1'b0;
        start     = 1'b1;
        seen      = 1'b0;
        for (n = 0; n < run_limit && !seen; n++) begin
            @(negedge clk);
            start = 1'b0;
            seen  = done;
            stall = stalls && !seen && (next_rand() % 4 == 0);
            if (poke && (n == 4 || n == 40)) begin   // loading, then hashing
                start  = 1'b1;
                kb     = ~kb;
                in_buf = ~in_buf;
            end
        end
        stall = 1'b0;
        if (!seen) begin
            errors++;
            $display("timeout: done did not arrive within %0d cycles", run_limit);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (errors == err_mark) begin
            tests_pass++;
            $display("test %0d %s: pass", test_num, name);
        end else begin
            tests_fail++;
            $display("test %0d %s: fail", test_num, name);
        end
        err_mark = errors;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        stall      = 1'b0;
        start      = 1'b0;
        kb         = '0;
        in_buf     = '0;
        rng        = 32'ha92faf19;
        exp_valid  = 1'b0;
        exp_key    = '0;
        last_kb    = '0;
        errors     = 0;
        err_mark   = 0;
        tests_pass = 0;
        tests_fail = 0;
        test_num   = 0;

        // the models themselves against published answers
        model_out = md5_of_block(pad_block(abc_msg, 3));
        assert (model_out == abc_md5)
            else begin
                errors++;
                $display("error model_out: got %h expected %h", model_out, abc_md5);
            end
        model_out = md5_of_block(pad_block(fox_msg, 43));
        assert (model_out == fox_md5)
            else begin
                errors++;
                $display("error model_out: got %h expected %h", model_out, fox_md5);
            end
        model_out = aes_encrypt(fips_pt, fips_key);
        assert (model_out == fips_ct)
            else begin
                errors++;
                $display("error model_out: got %h expected %h", model_out, fips_ct);
            end
        report_test("reference models");

        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < 30; i++) begin
            @(negedge clk);
            assert (!done)
                else begin
                    errors++;
                    $display("error done: got %h expected %h", done, 1'b0);
                end
            assert (!valid)
                else begin
                    errors++;
                    $display("error valid: got %h expected %h", valid, 1'b0);
                end
        end
        report_test("idle after reset");

        check_run(kb_vec[0], 1'b0, 1'b0, 1'b0);
        report_test("match vector 0");
        check_run(kb_vec[1], 1'b0, 1'b0, 1'b0);
        report_test("match vector 1");
        check_run(random_kb(), 1'b0, 1'b0, 1'b0);
        report_test("match random kb");

        check_run(last_kb, 1'b1, 1'b0, 1'b0);
        report_test("flipped in_buf bit");

        check_run(kb_vec[0], 1'b0, 1'b1, 1'b0);
        check_run(random_kb(), 1'b0, 1'b1, 1'b0);
        report_test("random stall");

        check_run(kb_vec[1], 1'b0, 1'b0, 1'b1);
        repeat (20) @(negedge clk);   // valid must hold here
        report_test("start while busy");

        $display("tests passed %0d failed %0d, errors %0d", tests_pass, tests_fail, errors);
        if (errors == 0 && tests_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rtl/md5_pkg.sv
rtl/aes_pkg.sv
rtl/md5_core.sv
rtl/aes_core.sv
rtl/kb_check_ctrl.sv
rtl/kb_check_top.sv
verif/kb_check_vectors.sv
verif/kb_check_tb.sv

// File: Bender.yml
package:
  name: kb_check

sources:
  - files:
      - rtl/md5_pkg.sv
      - rtl/aes_pkg.sv
      - rtl/md5_core.sv
      - rtl/aes_core.sv
      - rtl/kb_check_ctrl.sv
      - rtl/kb_check_top.sv
  - target: test
    files:
      - verif/kb_check_vectors.sv
      - verif/kb_check_tb.sv
